// ==== hw/stream_pkg.sv ====
package stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath types

    localparam int BEAT_BITS = 128;
    localparam int FID_BITS  = 12;
    localparam int TIME_BITS = 32;

    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [FID_BITS-1:0]  fid_t;
    typedef logic [TIME_BITS-1:0] time_t;   // real time

    //////////////////////////////////////////////////////////////////////
    // buffering and flow control

    localparam int BUF_DEPTH_LOG2  = 6;
    localparam int META_DEPTH_LOG2 = 3;     // meta and verdict queues
    localparam int OUT_DEPTH_LOG2  = 4;

    localparam int DATA_XOFF = 48;
    localparam int DATA_XON  = 32;
    localparam int META_XOFF = 6;
    localparam int META_XON  = 4;

    typedef enum logic {
        RD_IDLE,
        RD_READING
    } reader_state_t;

endpackage

// ==== hw/cert_pkg.sv ====
package cert_pkg;

    //////////////////////////////////////////////////////////////////////
    // certificate header layout in word positions from sop

    localparam int HDR_WORDS     = 6;
    localparam int SERIAL_WORD   = 1;
    localparam int DOMAIN_WORD   = 2;
    localparam int NOTAFTER_WORD = 3;
    localparam int MIN_WORDS     = 7;    // header plus one payload word
    localparam int REALIGN_BITS  = 32;

    localparam int SERIAL_BITS = 32;
    localparam int DOMAIN_BITS = 16;
    localparam int WIDX_BITS   = 8;      // saturates on long packets

    typedef logic [SERIAL_BITS-1:0] serial_t;
    typedef logic [DOMAIN_BITS-1:0] domain_t;
    typedef logic [WIDX_BITS-1:0]   widx_t;

    // one flow table entry
    typedef struct packed {
        stream_pkg::fid_t  fid;
        serial_t           serial;
        domain_t           domain;
        stream_pkg::time_t notafter;
        stream_pkg::time_t etime;
    } flow_rec_t;

endpackage

// ==== hw/buf_rd_if.sv ====
`timescale 1ns/1ns

interface buf_rd_if;
    import stream_pkg::*;

    logic  data_empty;
    beat_t data;
    logic  sop;
    logic  eop;
    logic  meta_empty;
    fid_t  fid;         // meta fifo head
    logic  data_rd;
    logic  meta_rd;

    modport source (
        output data_empty, data, sop, eop, meta_empty, fid,
        input  data_rd, meta_rd
    );

    modport sink (
        input  data_empty, data, sop, eop, meta_empty, fid,
        output data_rd, meta_rd
    );
endinterface

// ==== hw/cert_beat_if.sv ====
`timescale 1ns/1ns

interface cert_beat_if;
    import stream_pkg::*;
    import cert_pkg::*;

    logic  beat;        // one per buffer word read
    beat_t data;
    logic  sop;
    logic  eop;
    widx_t word_idx;
    logic  verdict_ok;
    fid_t  fid;

    modport source (
        output beat, data, sop, eop, word_idx, verdict_ok, fid
    );

    // consumers only listen
    modport sink (
        input  beat, data, sop, eop, word_idx, verdict_ok, fid
    );

endinterface

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr,
    input  logic [WIDTH-1:0]    din,
    input  logic                rd,
    output logic [WIDTH-1:0]    dout,
    output logic                empty,
    output logic                full,
    output logic [DEPTH_LOG2:0] count
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic                  do_wr;
    logic                  do_rd;

    assign empty = (count == '0);
    assign full  = count[DEPTH_LOG2];   // msb set only at DEPTH
    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;
    assign dout  = mem[rd_ptr];         // show-ahead head

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/ingress_buffer.sv ====
`timescale 1ns/1ns

module ingress_buffer #(
    parameter int BUF_DEPTH_LOG2  = 6,
    parameter int META_DEPTH_LOG2 = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              in_sop,
    input  logic              in_eop,
    input  stream_pkg::beat_t in_data,
    input  stream_pkg::fid_t  in_fid,
    output logic              in_ready,
    buf_rd_if.source          rd
);
    import stream_pkg::*;

    logic  valid_q;
    logic  sop_q;
    logic  eop_q;
    beat_t data_q;
    fid_t  fid_q;

    logic [BUF_DEPTH_LOG2:0]  data_count;
    logic [META_DEPTH_LOG2:0] meta_count;

    // input register stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        sop_q  <= in_sop;
        eop_q  <= in_eop;
        data_q <= in_data;
        fid_q  <= in_fid;
    end

    sync_fifo #(.WIDTH($bits(beat_t) + 2), .DEPTH_LOG2(BUF_DEPTH_LOG2)) data_fifo_i (
        .clk(clk), .rst_n(rst_n), .wr(valid_q), .din({data_q, sop_q, eop_q}),
        .rd(rd.data_rd), .dout({rd.data, rd.sop, rd.eop}), .empty(rd.data_empty),
        .full(), .count(data_count));

    sync_fifo #(.WIDTH($bits(fid_t)), .DEPTH_LOG2(META_DEPTH_LOG2)) meta_fifo_i (
        .clk(clk), .rst_n(rst_n), .wr(valid_q & sop_q), .din(fid_q),
        .rd(rd.meta_rd), .dout(rd.fid), .empty(rd.meta_empty),
        .full(), .count(meta_count));

    // ready hysteresis on both occupancies
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready <= 1'b1;
        end else if (data_count > DATA_XOFF || meta_count > META_XOFF) begin
            in_ready <= 1'b0;
        end else if (data_count < DATA_XON && meta_count < META_XON) begin
            in_ready <= 1'b1;
        end
    end

endmodule

// ==== hw/cert_reader.sv ====
`timescale 1ns/1ns

module cert_reader #(
    parameter int META_DEPTH_LOG2 = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sig_valid,
    input  logic        sig_ok,
    input  logic        room,
    buf_rd_if.sink      rd,
    cert_beat_if.source bt
);
    import stream_pkg::*;
    import cert_pkg::*;

    reader_state_t state;
    widx_t         idx;
    logic          start;
    logic          vq_empty;
    logic          vq_ok;

    // verdicts arrive in packet order
    sync_fifo #(.WIDTH(1), .DEPTH_LOG2(META_DEPTH_LOG2)) verdict_fifo_i (
        .clk(clk), .rst_n(rst_n), .wr(sig_valid), .din(sig_ok),
        .rd(rd.meta_rd), .dout(vq_ok), .empty(vq_empty),
        .full(), .count());

    assign start = (state == RD_IDLE) & ~rd.data_empty & rd.sop
                 & ~rd.meta_empty & ~vq_empty;

    assign rd.data_rd = (state == RD_READING) & ~rd.data_empty & room;
    assign rd.meta_rd = rd.data_rd & rd.eop;    // verdict pops too

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RD_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (start) begin
                        state <= RD_READING;
                    end
                end
                RD_READING: begin
                    if (rd.data_rd && rd.eop) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
            if (start) begin
                idx <= '0;
            end else if (rd.data_rd) begin
                idx <= (idx == '1) ? idx : idx + 1'b1;
            end
        end
    end

    assign bt.beat       = rd.data_rd;
    assign bt.data       = rd.data;
    assign bt.sop        = rd.sop;
    assign bt.eop        = rd.eop;
    assign bt.word_idx   = idx;
    assign bt.verdict_ok = vq_ok;
    assign bt.fid        = rd.fid;

endmodule

// ==== hw/cert_field_extract.sv ====
`timescale 1ns/1ns

module cert_field_extract (
    input  logic                clk,
    input  logic                rst_n,
    cert_beat_if.sink           bt,
    input  stream_pkg::time_t   current_time,
    input  stream_pkg::time_t   default_exp_time,
    output logic                rec_wr,
    output cert_pkg::flow_rec_t rec,
    output cert_pkg::domain_t   domain
);
    import stream_pkg::*;
    import cert_pkg::*;

    serial_t serial_q;
    domain_t domain_q;
    logic    at_serial;
    logic    at_domain;
    logic    at_notafter;

    assign at_serial   = bt.beat && (bt.word_idx == SERIAL_WORD);
    assign at_domain   = bt.beat && (bt.word_idx == DOMAIN_WORD);
    assign at_notafter = bt.beat && (bt.word_idx == NOTAFTER_WORD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_wr <= 1'b0;
        end else begin
            rec_wr <= at_notafter & bt.verdict_ok;  // failed packets leave no record
        end
    end

    always_ff @(posedge clk) begin
        if (at_serial) begin
            serial_q <= bt.data[SERIAL_BITS-1:0];
        end
        if (at_domain) begin
            domain_q <= bt.data[DOMAIN_BITS-1:0];
        end
        // record built on the not-after word
        if (at_notafter) begin
            rec.fid      <= bt.fid;
            rec.serial   <= serial_q;
            rec.domain   <= domain_q;
            rec.notafter <= bt.data[$bits(time_t)-1:0];
            rec.etime    <= current_time + default_exp_time;
        end
    end

    assign domain = domain_q;

endmodule

// ==== hw/payload_realign.sv ====
`timescale 1ns/1ns

module payload_realign #(
    parameter int OUT_DEPTH_LOG2 = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    cert_beat_if.sink         bt,
    input  cert_pkg::domain_t domain,
    output logic              room,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_sop,
    output logic              out_eop,
    output stream_pkg::beat_t out_data,
    output stream_pkg::fid_t  out_fid,
    output cert_pkg::domain_t out_domain,
    output logic              out_discard
);
    import stream_pkg::*;
    import cert_pkg::*;

    localparam int PAY_BITS  = $bits(beat_t) - REALIGN_BITS;
    localparam int META_BITS = $bits(fid_t) + $bits(domain_t) + 1;

    logic [REALIGN_BITS-1:0] last_lo;   // low word of previous beat
    logic                    tail_pend;
    logic                    emit;
    logic                    drop;
    logic                    first;
    logic                    beat_wr;
    beat_t                   beat_data;
    logic                    beat_sop;
    logic                    beat_eop;
    logic                    meta_wr;
    logic [META_BITS-1:0]    meta_din;
    logic                    beat_empty;
    logic                    meta_empty;
    logic                    beat_rd;
    logic [OUT_DEPTH_LOG2:0] beat_count;

    assign emit  = bt.beat & bt.verdict_ok & (bt.word_idx >= HDR_WORDS);
    assign drop  = bt.beat & ~bt.verdict_ok & bt.eop;
    assign first = (bt.word_idx == HDR_WORDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_pend <= 1'b0;
            beat_wr   <= 1'b0;
            meta_wr   <= 1'b0;
        end else begin
            tail_pend <= emit & bt.eop;     // reader idles next cycle so the slot is free
            beat_wr   <= emit | drop | tail_pend;
            meta_wr   <= (emit & first) | drop;
        end
    end

    always_ff @(posedge clk) begin
        if (bt.beat) begin
            last_lo <= bt.data[REALIGN_BITS-1:0];
        end
        if (tail_pend) begin
            beat_data <= {last_lo, {PAY_BITS{1'b0}}};
            beat_sop  <= 1'b0;
            beat_eop  <= 1'b1;
        end else begin
            beat_data <= bt.verdict_ok ? {last_lo, bt.data[$bits(beat_t)-1:REALIGN_BITS]} : '0;
            beat_sop  <= first | ~bt.verdict_ok;
            beat_eop  <= ~bt.verdict_ok;
        end
        meta_din <= {bt.fid, domain, ~bt.verdict_ok};
    end

    //////////////////////////////////////////////////////////////////////
    // output fifos with the meta entry written beside the sop beat

    sync_fifo #(.WIDTH($bits(beat_t) + 2), .DEPTH_LOG2(OUT_DEPTH_LOG2)) beat_fifo_i (
        .clk(clk), .rst_n(rst_n), .wr(beat_wr), .din({beat_data, beat_sop, beat_eop}),
        .rd(beat_rd), .dout({out_data, out_sop, out_eop}), .empty(beat_empty),
        .full(), .count(beat_count));

    sync_fifo #(.WIDTH(META_BITS), .DEPTH_LOG2(OUT_DEPTH_LOG2)) meta_fifo_i (
        .clk(clk), .rst_n(rst_n), .wr(meta_wr), .din(meta_din),
        .rd(beat_rd & out_eop), .dout({out_fid, out_domain, out_discard}),
        .empty(meta_empty), .full(), .count());

    assign out_valid = ~beat_empty & ~meta_empty;
    assign beat_rd   = out_valid & out_ready;
    assign room      = (beat_count + 3) <= (1 << OUT_DEPTH_LOG2);  // two writes in flight plus tail

endmodule

// ==== hw/cert_process_top.sv ====
`timescale 1ns/1ns

module cert_process_top #(
    parameter int BUF_DEPTH_LOG2  = stream_pkg::BUF_DEPTH_LOG2,
    parameter int META_DEPTH_LOG2 = stream_pkg::META_DEPTH_LOG2,
    parameter int OUT_DEPTH_LOG2  = stream_pkg::OUT_DEPTH_LOG2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              in_sop,
    input  logic              in_eop,
    input  stream_pkg::beat_t in_data,
    input  stream_pkg::fid_t  in_fid,
    output logic              in_ready,
    input  logic              sig_valid,
    input  logic              sig_ok,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_sop,
    output logic              out_eop,
    output stream_pkg::beat_t out_data,
    output stream_pkg::fid_t  out_fid,
    output cert_pkg::domain_t out_domain,
    output logic              out_discard,
    input  stream_pkg::time_t current_time,
    input  stream_pkg::time_t default_exp_time,
    output logic              rec_wr,
    output stream_pkg::fid_t  rec_fid,
    output cert_pkg::serial_t rec_serial,
    output cert_pkg::domain_t rec_domain,
    output stream_pkg::time_t rec_notafter,
    output stream_pkg::time_t rec_etime
);
    import cert_pkg::*;

    buf_rd_if    rd_if ();
    cert_beat_if bt_if ();

    logic      room;
    domain_t   domain;
    flow_rec_t rec;

    ingress_buffer #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2), .META_DEPTH_LOG2(META_DEPTH_LOG2))
    ingress_buffer_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_sop(in_sop), .in_eop(in_eop),
        .in_data(in_data), .in_fid(in_fid), .in_ready(in_ready), .rd(rd_if));

    cert_reader #(.META_DEPTH_LOG2(META_DEPTH_LOG2)) cert_reader_i (
        .clk(clk), .rst_n(rst_n), .sig_valid(sig_valid), .sig_ok(sig_ok),
        .room(room), .rd(rd_if), .bt(bt_if));

    cert_field_extract cert_field_extract_i (
        .clk(clk), .rst_n(rst_n), .bt(bt_if), .current_time(current_time),
        .default_exp_time(default_exp_time), .rec_wr(rec_wr), .rec(rec), .domain(domain));

    payload_realign #(.OUT_DEPTH_LOG2(OUT_DEPTH_LOG2)) payload_realign_i (
        .clk(clk), .rst_n(rst_n), .bt(bt_if), .domain(domain), .room(room),
        .out_valid(out_valid), .out_ready(out_ready), .out_sop(out_sop), .out_eop(out_eop),
        .out_data(out_data), .out_fid(out_fid), .out_domain(out_domain),
        .out_discard(out_discard));

    // flatten the record
    assign rec_fid      = rec.fid;
    assign rec_serial   = rec.serial;
    assign rec_domain   = rec.domain;
    assign rec_notafter = rec.notafter;
    assign rec_etime    = rec.etime;

endmodule

// ==== bench/cert_process_chk.sv ====
`timescale 1ns/1ns

module cert_process_chk (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              out_valid,
    input  logic              out_ready,
    input  logic              out_sop,
    input  logic              out_eop,
    input  stream_pkg::beat_t out_data,
    input  stream_pkg::fid_t  out_fid,
    input  cert_pkg::domain_t out_domain,
    input  logic              out_discard,
    input  logic              rec_wr
);
    int unsigned fails = 0;     // failed assertion count

    // held beat may not move under back-pressure
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid
            && $stable({out_sop, out_eop, out_data, out_fid, out_domain, out_discard}))
    else begin
        fails++;
        $error("output beat changed while stalled");
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin
        fails++;
        $error("out_valid high during reset");
    end

    rec_pulse: assert property (@(posedge clk) disable iff (!rst_n) rec_wr |=> !rec_wr)
    else begin
        fails++;
        $error("rec_wr held for two cycles");
    end

endmodule

bind cert_process_top cert_process_chk cert_process_chk_i (.*);

// ==== bench/cert_process_tb.sv ====
`timescale 1ns/1ns

module cert_process_tb;
    import stream_pkg::*;
    import cert_pkg::*;

    localparam int N_ROWS = 14;
    localparam int ALWAYS = 0;
    localparam int RANDOM = 1;
    localparam int HOLD   = 2;      // out_ready low for a span of cycles

    typedef struct packed {
        beat_t   data;
        fid_t    fid;
        domain_t domain;
        logic    sop;
        logic    eop;
        logic    discard;
        logic    chk_data;          // off for discard beats
    } exp_beat_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    logic      in_sop;
    logic      in_eop;
    beat_t     in_data;
    fid_t      in_fid;
    logic      in_ready;
    logic      sig_valid = 1'b0;
    logic      sig_ok = 1'b0;
    logic      out_valid;
    logic      out_ready = 1'b0;
    logic      out_sop;
    logic      out_eop;
    beat_t     out_data;
    fid_t      out_fid;
    domain_t   out_domain;
    logic      out_discard;
    time_t     current_time;
    time_t     default_exp_time;
    logic      rec_wr;
    fid_t      rec_fid;
    serial_t   rec_serial;
    domain_t   rec_domain;
    time_t     rec_notafter;
    time_t     rec_etime;

    // packet table
    int        row_fid [N_ROWS];
    int        row_words [N_ROWS];
    bit        row_ok [N_ROWS];
    int        row_delay [N_ROWS];
    int        row_mode [N_ROWS];
    int        row_span [N_ROWS];
    int        n_rows = 0;

    beat_t     stim [$];
    int        pkt_base [N_ROWS];
    exp_beat_t exp_beats [$];
    flow_rec_t exp_recs [$];

    integer    seed = 32'h8624;
    int        errors = 0;
    int        checks = 0;
    int        sop_count = 0;
    int        cycle = 0;
    int        hold_until = 0;
    int        limit = 300;
    bit        rdy_random = 1'b0;
    bit        table_loaded = 1'b0;
    bit        ready_dropped = 1'b0;

    cert_process_top cert_process_top_i (.*);

    always #5 clk = ~clk;

    task automatic add_row(input int fid, input int words, input bit ok, input int delay,
                           input int mode, input int span);
        row_fid[n_rows]   = fid;
        row_words[n_rows] = words;
        row_ok[n_rows]    = ok;
        row_delay[n_rows] = delay;
        row_mode[n_rows]  = mode;
        row_span[n_rows]  = span;
        n_rows++;
    endtask

    // reference model builds every expectation before the run
    task automatic build_expected();
        int        base;
        int        n;
        exp_beat_t eb;
        flow_rec_t r;
        for (int p = 0; p < N_ROWS; p++) begin
            base = stim.size();
            n = row_words[p];
            pkt_base[p] = base;
            for (int w = 0; w < n; w++) begin
                stim.push_back({$random(seed), $random(seed), $random(seed), $random(seed)});
            end
            limit += 4 * n + row_delay[p] + row_span[p];
            eb = '0;
            eb.fid = row_fid[p];
            if (!row_ok[p]) begin
                eb.sop = 1'b1;
                eb.eop = 1'b1;
                eb.discard = 1'b1;
                exp_beats.push_back(eb);
            end else begin
                eb.domain = stim[base + 2][15:0];
                eb.chk_data = 1'b1;
                for (int k = 0; k <= n - 7; k++) begin
                    eb.data = {stim[base + 5 + k][31:0], stim[base + 6 + k][127:32]};
                    eb.sop = (k == 0);
                    exp_beats.push_back(eb);
                end
                eb.data = {stim[base + n - 1][31:0], 96'b0};   // trailing beat
                eb.sop = 1'b0;
                eb.eop = 1'b1;
                exp_beats.push_back(eb);
                r.fid = row_fid[p];
                r.serial = stim[base + 1][31:0];
                r.domain = stim[base + 2][15:0];
                r.notafter = stim[base + 3][31:0];
                r.etime = current_time + default_exp_time;
                exp_recs.push_back(r);
            end
        end
    endtask

    task automatic send_packet(input int p);
        int w;
        w = 0;
        rdy_random <= (row_mode[p] == RANDOM);
        if (row_mode[p] == HOLD) begin
            hold_until <= cycle + row_span[p];
        end
        while (w < row_words[p]) begin
            @(posedge clk);
            if (in_ready) begin
                in_valid <= 1'b1;
                in_sop   <= (w == 0);
                in_eop   <= (w == row_words[p] - 1);
                in_data  <= stim[pkt_base[p] + w];
                in_fid   <= row_fid[p];
                if (w == 0) begin
                    sop_count++;
                end
                w++;
            end else begin
                in_valid <= 1'b0;
            end
        end
    endtask

    task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic void print_summary();
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 cert_process_top_i.cert_process_chk_i.fails);
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // verdicts in packet order some cycles after each sop

    initial begin : verdicts
        for (int p = 0; p < N_ROWS; p++) begin
            wait (sop_count > p);
            repeat (row_delay[p] + 1) @(posedge clk);
            sig_valid <= 1'b1;
            sig_ok    <= row_ok[p];
            @(posedge clk);
            sig_valid <= 1'b0;
        end
    end

    always @(posedge clk) begin : ready_gen
        integer rnd;
        cycle <= cycle + 1;
        if (!rst_n || cycle < hold_until) begin
            out_ready <= 1'b0;
        end else if (rdy_random) begin
            rnd = $random(seed);
            out_ready <= rnd[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // output and record monitor

    always @(posedge clk) begin : monitor
        exp_beat_t eb;
        flow_rec_t er;
        if (rst_n) begin
            if (!in_ready) begin
                ready_dropped = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_beats.size() == 0) begin
                    errors++;
                    $display("output beat at %0t arrived with none left to expect", $time);
                end else begin
                    eb = exp_beats.pop_front();
                    compare("out_sop", out_sop, eb.sop);
                    compare("out_eop", out_eop, eb.eop);
                    compare("out_discard", out_discard, eb.discard);
                    compare("out_fid", out_fid, eb.fid);
                    if (eb.chk_data) begin
                        compare("out_data", out_data, eb.data);
                        compare("out_domain", out_domain, eb.domain);
                    end
                end
            end
            if (rec_wr) begin
                if (exp_recs.size() == 0) begin
                    errors++;
                    $display("record write at %0t with no record left to expect", $time);
                end else begin
                    er = exp_recs.pop_front();
                    compare("rec_fid", rec_fid, er.fid);
                    compare("rec_serial", rec_serial, er.serial);
                    compare("rec_domain", rec_domain, er.domain);
                    compare("rec_notafter", rec_notafter, er.notafter);
                    compare("rec_etime", rec_etime, er.etime);
                end
            end
        end
    end

    initial begin : watchdog
        wait (table_loaded);
        repeat (limit) @(posedge clk);
        $display("timeout: packets still missing after %0d cycles", limit);
        print_summary();
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n = 1'b1;
        in_valid = 1'b0;
        in_sop = 1'b0;
        in_eop = 1'b0;
        in_data = '0;
        in_fid = '0;
        current_time = 32'h0001_2340;
        default_exp_time = 32'h0000_0e10;
        //       fid      words ok delay mode    span
        add_row(12'h101,  7, 1,  0, ALWAYS,   0);
        add_row(12'h102, 10, 1,  3, ALWAYS,   0);
        add_row(12'h103,  9, 0,  2, ALWAYS,   0);
        add_row(12'h104, 16, 1,  0, RANDOM,   0);
        add_row(12'h105,  8, 0,  5, RANDOM,   0);
        add_row(12'h106, 13, 1,  1, RANDOM,   0);
        add_row(12'h107, 20, 1,  0, HOLD,   200);   // burst into a stalled output
        add_row(12'h108, 18, 1,  0, ALWAYS,   0);
        add_row(12'h109, 15, 0,  0, ALWAYS,   0);
        add_row(12'h10a, 22, 1,  0, ALWAYS,   0);
        add_row(12'h10b, 17, 1,  0, ALWAYS,   0);
        add_row(12'h10c, 11, 1, 60, ALWAYS,   0);   // late verdict
        add_row(12'h10d,  7, 0,  0, ALWAYS,   0);
        add_row(12'h10e,  9, 1,  0, RANDOM,   0);
        build_expected();
        table_loaded = 1'b1;
        #1 rst_n = 1'b0;    // clean negedge for the async reset
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < N_ROWS; p++) begin
            send_packet(p);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_beats.size() != 0 || exp_recs.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (!ready_dropped) begin
            errors++;
            $display("in_ready never fell while the output was held low");
        end
        print_summary();
        if (errors == 0 && cert_process_top_i.cert_process_chk_i.fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/stream_pkg.sv
hw/cert_pkg.sv
hw/buf_rd_if.sv
hw/cert_beat_if.sv
hw/sync_fifo.sv
hw/ingress_buffer.sv
hw/cert_reader.sv
hw/cert_field_extract.sv
hw/payload_realign.sv
hw/cert_process_top.sv
bench/cert_process_chk.sv
bench/cert_process_tb.sv
